// File: hw/fme_pkg.sv
`default_nettype none

package fme_pkg;

	localparam int PIXEL_WIDTH    = 8;
	localparam int ROW_PIXELS     = 16;
	localparam int TAPS           = 8;
	localparam int HALF_POSITIONS = ROW_PIXELS - TAPS + 1; // 9 half-pel samples per row
	localparam int FILTER_SHIFT   = 6;
	localparam int SUM_WIDTH      = 16;

	localparam logic signed [SUM_WIDTH-1:0] FILTER_ROUND = 16'sd32;

	// half-pel luma taps, sum is 64
	localparam logic signed [SUM_WIDTH-1:0] FILTER_COEFS [TAPS] = '{
		-16'sd1, 16'sd4, -16'sd11, 16'sd40, 16'sd40, -16'sd11, 16'sd4, -16'sd1
	};

	typedef logic [PIXEL_WIDTH-1:0] pixel_t;
	typedef logic [3:0] position_t;

	typedef struct packed {
		logic      valid;
		position_t position;
	} tap_req_t;

	typedef struct packed {
		logic      valid;
		position_t position;
		pixel_t    pixel;
	} half_sample_t;

	typedef struct packed {
		logic             we;
		logic             row;    // 0 upper, 1 lower
		logic [1:0]       word;
		pixel_t [3:0]     pixels; // pixel 0 in low byte
	} pixel_write_t;

endpackage

`default_nettype wire

// File: hw/wb_pkg.sv
`default_nettype none

package wb_pkg;

	localparam int WB_DATA_WIDTH = 32;
	localparam int WB_ADDR_WIDTH = 5;

	// word address map
	localparam logic [WB_ADDR_WIDTH-1:0] ADDR_UPPER_BASE  = 5'd0;
	localparam logic [WB_ADDR_WIDTH-1:0] ADDR_LOWER_BASE  = 5'd4;
	localparam logic [WB_ADDR_WIDTH-1:0] ADDR_CONTROL     = 5'd8;
	localparam logic [WB_ADDR_WIDTH-1:0] ADDR_STATUS      = 5'd9;
	localparam logic [WB_ADDR_WIDTH-1:0] ADDR_RESULT_BASE = 5'd16;

	typedef struct packed {
		logic                     cyc;
		logic                     stb;
		logic                     we;
		logic [WB_ADDR_WIDTH-1:0] addr;
		logic [WB_DATA_WIDTH-1:0] data;
	} wb_req_t;

	typedef struct packed {
		logic                     ack;
		logic [WB_DATA_WIDTH-1:0] data;
	} wb_rsp_t;

	typedef struct packed {
		logic [WB_DATA_WIDTH-2:0] reserved;
		logic                     start;
	} wb_control_t;

	// same word seen as row pixels or as control
	typedef union packed {
		fme_pkg::pixel_t [3:0] pixels;
		wb_control_t           control;
	} wb_word_u;

endpackage

`default_nettype wire

// File: hw/fme_host_port.sv
`timescale 1ns/1ps
`default_nettype none

module fme_host_port (
	input  wire                                 clock,
	input  wire                                 reset,
	input  wire wb_pkg::wb_req_t                wb_req,
	input  wire                                 done,
	input  wire [wb_pkg::WB_DATA_WIDTH-1:0]     result_word,
	output wb_pkg::wb_rsp_t                     wb_rsp,
	output fme_pkg::pixel_write_t               pixel_write,
	output fme_pkg::tap_req_t                   tap_req,
	output fme_pkg::position_t                  result_position,
	output logic                                busy
);

	wb_pkg::wb_word_u                 wdata;
	logic                             cycle;
	logic                             pixel_sel;
	logic                             lower_sel;
	logic                             start;
	logic [wb_pkg::WB_DATA_WIDTH-1:0] rdata;
	fme_pkg::position_t               step;

	assign cycle     = wb_req.cyc & wb_req.stb & ~wb_rsp.ack; // first clock of a request
	assign wdata     = wb_req.data;
	assign pixel_sel = wb_req.addr < wb_pkg::ADDR_CONTROL;
	assign lower_sel = wb_req.addr >= wb_pkg::ADDR_LOWER_BASE;

	assign start = cycle & wb_req.we & ~busy
		& (wb_req.addr == wb_pkg::ADDR_CONTROL) & wdata.control.start;

	always_comb begin
		pixel_write.we     = cycle & wb_req.we & pixel_sel & ~busy; // rows frozen during a run
		pixel_write.row    = lower_sel;
		pixel_write.word   = wb_req.addr[1:0]; // word within the row
		pixel_write.pixels = wdata.pixels;
	end

	assign result_position = fme_pkg::position_t'(wb_req.addr - wb_pkg::ADDR_RESULT_BASE);

	always_comb begin
		rdata = '0;
		if (wb_req.addr == wb_pkg::ADDR_STATUS) begin
			rdata[0] = busy;
			rdata[1] = done;
		end else if (wb_req.addr >= wb_pkg::ADDR_RESULT_BASE) begin
			rdata = result_word; // merge zeroes positions past 8
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			wb_rsp <= '0;
		end else begin
			wb_rsp.ack  <= cycle;
			wb_rsp.data <= (cycle && !wb_req.we) ? rdata : '0;
		end
	end

	// run sequencer: one tap request per clock, then wait out the filter pipe
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			busy    <= 1'b0;
			step    <= '0;
			tap_req <= '0;
		end else if (start) begin
			busy          <= 1'b1;
			step          <= '0;
			tap_req.valid <= 1'b0;
		end else if (busy) begin
			tap_req.valid    <= step < fme_pkg::HALF_POSITIONS;
			tap_req.position <= step;
			step             <= step + 1'b1;
			if (step == fme_pkg::HALF_POSITIONS + 2) begin // two filter stages
				busy <= 1'b0;
			end
		end
	end

	ack_single_cycle: assert property (
		@(posedge clock) disable iff (reset) wb_rsp.ack |=> !wb_rsp.ack
	) else $error("ack held for two cycles");

	tap_position_range: assert property (
		@(posedge clock) disable iff (reset)
		tap_req.valid |-> tap_req.position < fme_pkg::HALF_POSITIONS
	) else $error("tap request past last half-pel position");

endmodule

`default_nettype wire

// File: hw/row_interpolator.sv
`timescale 1ns/1ps
`default_nettype none

module row_interpolator (
	input  wire                         clock,
	input  wire                         reset,
	input  wire                         row_select,
	input  wire fme_pkg::pixel_write_t  pixel_write,
	input  wire fme_pkg::tap_req_t      tap_req,
	output fme_pkg::half_sample_t       sample
);

	fme_pkg::pixel_t [fme_pkg::ROW_PIXELS-1:0] row_store;
	logic signed [fme_pkg::SUM_WIDTH-1:0]      tap_sum;
	logic signed [fme_pkg::SUM_WIDTH-1:0]      tap_pixel;
	logic signed [fme_pkg::SUM_WIDTH-1:0]      rounded;
	fme_pkg::pixel_t                           clipped;
	logic                                      s1_valid;
	fme_pkg::position_t                        s1_position;
	logic signed [fme_pkg::SUM_WIDTH-1:0]      s1_sum;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			row_store <= '0;
		end else if (pixel_write.we && pixel_write.row == row_select) begin
			row_store[{pixel_write.word, 2'b00} +: 4] <= pixel_write.pixels;
		end
	end

	// eight pixels starting at the requested position
	always_comb begin
		tap_sum = '0;
		for (int k = 0; k < fme_pkg::TAPS; k++) begin
			tap_pixel = row_store[tap_req.position + k]; // zero extended
			tap_sum   = tap_sum + fme_pkg::FILTER_COEFS[k] * tap_pixel;
		end
	end

	always_comb begin
		rounded = (s1_sum + fme_pkg::FILTER_ROUND) >>> fme_pkg::FILTER_SHIFT;
		if (rounded[fme_pkg::SUM_WIDTH-1]) begin
			clipped = '0; // negative
		end else if (|rounded[fme_pkg::SUM_WIDTH-2:fme_pkg::PIXEL_WIDTH]) begin
			clipped = '1; // above 255
		end else begin
			clipped = rounded[fme_pkg::PIXEL_WIDTH-1:0];
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			s1_valid    <= 1'b0;
			s1_position <= '0;
			sample      <= '0;
		end else begin
			s1_valid        <= tap_req.valid;
			s1_position     <= tap_req.position;
			sample.valid    <= s1_valid;
			sample.position <= s1_position;
			sample.pixel    <= clipped;
		end
	end

	always_ff @(posedge clock) begin
		s1_sum <= tap_sum;
	end

	row_stable_in_run: assert property (
		@(posedge clock) disable iff (reset) tap_req.valid |=> $stable(row_store)
	) else $error("row store changed during a run");

endmodule

`default_nettype wire

// File: hw/halfpel_merge.sv
`timescale 1ns/1ps
`default_nettype none

module halfpel_merge (
	input  wire                              clock,
	input  wire                              reset,
	input  wire fme_pkg::half_sample_t       upper_sample,
	input  wire fme_pkg::half_sample_t       lower_sample,
	input  wire                              busy,
	input  wire fme_pkg::position_t          result_position,
	output logic [wb_pkg::WB_DATA_WIDTH-1:0] result_word,
	output logic                             done
);

	// per position: [0] upper, [1] lower, [2] merged
	fme_pkg::pixel_t [2:0]            result_buf [fme_pkg::HALF_POSITIONS];
	logic [fme_pkg::PIXEL_WIDTH:0]    pair_sum;
	fme_pkg::pixel_t                  merged;

	always_comb begin
		pair_sum = {1'b0, upper_sample.pixel} + {1'b0, lower_sample.pixel} + 1'b1;
		merged   = pair_sum[fme_pkg::PIXEL_WIDTH:1]; // rounded average
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int p = 0; p < fme_pkg::HALF_POSITIONS; p++) begin
				result_buf[p] <= '0;
			end
			done <= 1'b0;
		end else begin
			if (upper_sample.valid) begin
				result_buf[upper_sample.position] <=
					{merged, lower_sample.pixel, upper_sample.pixel};
			end
			if (upper_sample.valid && upper_sample.position == fme_pkg::HALF_POSITIONS - 1) begin
				done <= 1'b1;
			end else if (busy) begin
				done <= 1'b0; // new run started
			end
		end
	end

	always_comb begin
		result_word = '0;
		if (result_position < fme_pkg::HALF_POSITIONS) begin
			result_word[3*fme_pkg::PIXEL_WIDTH-1:0] = result_buf[result_position];
		end
	end

	rows_in_step: assert property (
		@(posedge clock) disable iff (reset)
		upper_sample.valid == lower_sample.valid
			&& (!upper_sample.valid || upper_sample.position == lower_sample.position)
	) else $error("upper and lower samples out of step");

endmodule

`default_nettype wire

// File: hw/fme_top.sv
`timescale 1ns/1ps
`default_nettype none

module fme_top (
	input  wire                   clock,
	input  wire                   reset,
	input  wire wb_pkg::wb_req_t  wb_req,
	output wb_pkg::wb_rsp_t       wb_rsp
);

	fme_pkg::pixel_write_t            pixel_write;
	fme_pkg::tap_req_t                tap_req;
	fme_pkg::half_sample_t            upper_sample;
	fme_pkg::half_sample_t            lower_sample;
	fme_pkg::position_t               result_position;
	logic [wb_pkg::WB_DATA_WIDTH-1:0] result_word;
	logic                             busy;
	logic                             done;

	fme_host_port host_port (
		.clock           (clock),
		.reset           (reset),
		.wb_req          (wb_req),
		.done            (done),
		.result_word     (result_word),
		.wb_rsp          (wb_rsp),
		.pixel_write     (pixel_write),
		.tap_req         (tap_req),
		.result_position (result_position),
		.busy            (busy)
	);

	row_interpolator upper_row (
		.clock       (clock),
		.reset       (reset),
		.row_select  (1'b0),
		.pixel_write (pixel_write),
		.tap_req     (tap_req),
		.sample      (upper_sample)
	);

	row_interpolator lower_row (
		.clock       (clock),
		.reset       (reset),
		.row_select  (1'b1),
		.pixel_write (pixel_write),
		.tap_req     (tap_req),
		.sample      (lower_sample)
	);

	halfpel_merge merge (
		.clock           (clock),
		.reset           (reset),
		.upper_sample    (upper_sample),
		.lower_sample    (lower_sample),
		.busy            (busy),
		.result_position (result_position),
		.result_word     (result_word),
		.done            (done)
	);

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock; // 8 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clock);
		#1 reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: verif/fme_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fme_checker (
	input wire                   clock,
	input wire                   reset,
	input wire wb_pkg::wb_req_t  wb_req,
	input wire wb_pkg::wb_rsp_t  wb_rsp
);

	int                               mismatches = 0;
	int                               other_errors = 0;
	logic [wb_pkg::WB_DATA_WIDTH-1:0] expected [32];
	logic                             known [32];
	logic                             ack_due = 1'b0;
	logic [wb_pkg::WB_ADDR_WIDTH-1:0] pend_addr = '0;
	logic                             pend_we = 1'b0;

	initial begin
		for (int a = 0; a < 32; a++) begin
			expected[a] = '0;
			known[a]    = 1'b0;
		end
	end

	task automatic expect_word(input int addr, input logic [31:0] value);
		expected[addr] = value;
		known[addr]    = 1'b1;
	endtask

	task automatic ignore_word(input int addr);
		known[addr] = 1'b0;
	endtask

	task automatic note_error(input string msg);
		other_errors++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	// values sampled here are the ones from before the edge
	always @(posedge clock) begin
		if (reset) begin
			ack_due = 1'b0;
		end else begin
			if (ack_due && !wb_rsp.ack) begin
				note_error("no ack on the clock after a request");
			end else if (!ack_due && wb_rsp.ack) begin
				note_error("ack without a new request or held for two clocks");
			end
			if (ack_due && wb_rsp.ack && !pend_we && known[pend_addr]) begin
				if (wb_rsp.data !== expected[pend_addr]) begin
					mismatches++;
					$display("MISMATCH wb_rsp.data addr %h expected %h actual %h",
						pend_addr, expected[pend_addr], wb_rsp.data);
				end
			end
			ack_due   = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
			pend_addr = wb_req.addr;
			pend_we   = wb_req.we;
		end
	end

endmodule

`default_nettype wire

// File: verif/tb_fme.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fme;

	logic            clock;
	logic            reset;
	wb_pkg::wb_req_t wb_req;
	wb_pkg::wb_rsp_t wb_rsp;

	logic [7:0]  up_row [16];
	logic [7:0]  lo_row [16];
	logic [31:0] exp_word [9];
	int          seed = 52253;
	int          n_tests = 0;
	logic [31:0] rdata;

	tb_clock clock_gen (.clock(clock), .reset(reset));

	fme_top uut (.clock(clock), .reset(reset), .wb_req(wb_req), .wb_rsp(wb_rsp));

	fme_checker check_unit (.clock(clock), .reset(reset), .wb_req(wb_req), .wb_rsp(wb_rsp));

	task automatic wb_access(input logic we, input int addr, input logic [31:0] data,
		output logic [31:0] rd);
		@(posedge clock);
		#1;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, addr: 5'(addr), data: data};
		do begin
			@(posedge clock);
			#1;
		end while (!wb_rsp.ack);
		rd     = wb_rsp.data;
		wb_req = '0;
	endtask

	task automatic checked_read(input int addr, input logic [31:0] value);
		check_unit.expect_word(addr, value);
		wb_access(1'b0, addr, '0, rdata);
	endtask

	function automatic logic [7:0] filter_half(input logic [7:0] row [16], input int p);
		int coef [8] = '{-1, 4, -11, 40, 40, -11, 4, -1};
		int sum;
		sum = 0;
		for (int k = 0; k < 8; k++) begin
			sum += coef[k] * int'(row[p + k]);
		end
		sum = (sum + 32) >>> 6;
		if (sum < 0) return 8'h00;
		if (sum > 255) return 8'hff;
		return 8'(sum);
	endfunction

	// writes both rows if asked, runs once, checks status and all nine results
	task automatic run_once(input bit load_rows, input bit disturb);
		time start_time;
		int  run_cycles;
		if (load_rows) begin
			for (int w = 0; w < 8; w++) begin
				if (w < 4) begin
					wb_access(1'b1, w, {up_row[4*w+3], up_row[4*w+2], up_row[4*w+1],
						up_row[4*w]}, rdata);
				end else begin
					wb_access(1'b1, w, {lo_row[4*w-13], lo_row[4*w-14], lo_row[4*w-15],
						lo_row[4*w-16]}, rdata);
				end
			end
		end
		for (int p = 0; p < 9; p++) begin
			check_unit.expect_word(16 + p, exp_word[p]);
		end
		wb_access(1'b1, 8, 32'h1, rdata);
		start_time = $time;
		checked_read(9, 32'h1); // busy, done cleared
		if (disturb) begin
			wb_access(1'b1, 0, 32'hffff_ffff, rdata);
			wb_access(1'b1, 8, 32'h1, rdata);
		end
		check_unit.ignore_word(9);
		do begin
			wb_access(1'b0, 9, '0, rdata);
		end while (rdata == 32'h1);
		// done is due 12 cycles after the start ack, status reads come every 2
		run_cycles = int'(($time - start_time) / 8);
		if (run_cycles < 13 || run_cycles > 14) begin
			check_unit.note_error($sformatf("run ended %0d cycles after start, expected 13 or 14",
				run_cycles));
		end
		checked_read(9, 32'h2);
		for (int p = 0; p < 9; p++) begin
			wb_access(1'b0, 16 + p, '0, rdata);
		end
	endtask

	task automatic random_rows();
		for (int i = 0; i < 16; i++) begin
			up_row[i] = 8'($random(seed));
			lo_row[i] = 8'($random(seed));
		end
		for (int p = 0; p < 9; p++) begin
			exp_word[p] = {8'h00, 8'((int'(filter_half(up_row, p)) + int'(filter_half(lo_row, p))
				+ 1) >> 1), filter_half(lo_row, p), filter_half(up_row, p)};
		end
	endtask

	initial begin
		int    fd;
		string line;
		string lines [$];
		logic [7:0] b [59];
		wb_req = '0;
		fd = $fopen("verif/fme_vectors.txt", "r");
		if (fd == 0) begin
			check_unit.note_error("could not open verif/fme_vectors.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() >= 176 && line.substr(0, 0) != "#") begin
					lines.push_back(line);
				end
			end
			$fclose(fd);
		end
		n_tests = lines.size() + 11;
		wait (!reset);
		checked_read(9, 32'h0);
		checked_read(10, 32'h0);
		checked_read(12, 32'h0);
		checked_read(31, 32'h0);
		foreach (lines[n]) begin
			for (int i = 0; i < 59; i++) begin
				b[i] = 8'(lines[n].substr(3*i, 3*i+1).atohex());
			end
			for (int i = 0; i < 16; i++) begin
				up_row[i] = b[i];
				lo_row[i] = b[16 + i];
			end
			for (int p = 0; p < 9; p++) begin
				exp_word[p] = {8'h00, b[50 + p], b[41 + p], b[32 + p]};
			end
			run_once(1'b1, 1'b0);
		end
		for (int t = 0; t < 10; t++) begin
			random_rows();
			run_once(1'b1, t == 0);
			if (t == 0) begin
				run_once(1'b0, 1'b0); // rows must be untouched by the write during busy
			end
		end
		$display("mismatches: %0d, other errors: %0d", check_unit.mismatches,
			check_unit.other_errors);
		if (check_unit.mismatches == 0 && check_unit.other_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin
		wait (n_tests > 0);
		#((n_tests * 60 + 200) * 8);
		check_unit.note_error("timeout, run did not finish");
		$display("mismatches: %0d, other errors: %0d", check_unit.mismatches,
			check_unit.other_errors);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/fme_vectors.txt
# columns: 16 upper pixels, 16 lower pixels, then expected bytes in hex
# 9 upper samples, 9 lower samples, 9 merged samples
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 40 40 40 40 40 40 40 40 40 80 80 80 80 80 80 80 80 80 60 60 60 60 60 60 60 60 60
00 00 00 00 00 00 00 00 FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF 00 00 00 00 00 00 00 00 00 00 0C 00 80 FF F3 FF FF FF FF F3 FF 80 00 0C 00 00 80 80 80 80 80 80 80 80 80
00 10 20 30 40 50 60 70 80 90 A0 B0 C0 D0 E0 F0 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 38 48 58 68 78 88 98 A8 B8 20 20 20 20 20 20 20 20 20 2C 34 3C 44 4C 54 5C 64 6C
FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 FF FF FF FF FF FF FF FF FF 00 00 00 00 00 00 00 00 00 80 80 80 80 80 80 80 80 80

// File: sim.f
hw/fme_pkg.sv
hw/wb_pkg.sv
hw/fme_host_port.sv
hw/row_interpolator.sv
hw/halfpel_merge.sv
hw/fme_top.sv
verif/tb_clock.sv
verif/fme_checker.sv
verif/tb_fme.sv
